/* action_engine.f */
+incdir+hw
hw/action_engine_pkg.sv
hw/operand_if.sv
hw/engine_ctrl.sv
hw/operand_crossbar.sv
hw/container_alu.sv
hw/action_engine.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/tb_action_engine.sv

/* hw/action_engine.sv */
// action engine
// one match-action stage: slices the header and action vectors into
// three width classes, selects operands per slot and runs twelve
// container ALUs; two cycles from input strobe to output
`timescale 1ns/10ps
`include "action_engine_settings.svh"

module action_engine
    import action_engine_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`AE_PHV_W-1:0]    phv_in,
    input  logic                    phv_valid_in,
    input  logic [`AE_ACT_W-1:0]    action_in,
    input  logic                    action_valid_in,
    output logic [`AE_PHV_W-1:0]    phv_out,
    output logic                    phv_valid_out
);

    // class offsets inside the header vector
    localparam int OFF_4B = `AE_PER_CLASS * `AE_W2B;
    localparam int OFF_6B = OFF_4B + `AE_PER_CLASS * `AE_W4B;

    action_slot_t   slots [`AE_NUM_SLOTS];
    action_slot_t   slots_2b [`AE_PER_CLASS];
    action_slot_t   slots_4b [`AE_PER_CLASS];
    action_slot_t   slots_6b [`AE_PER_CLASS];
    c2b_t           cont_2b [`AE_PER_CLASS];
    c4b_t           cont_4b [`AE_PER_CLASS];
    c6b_t           cont_6b [`AE_PER_CLASS];

    operand_if #(.data_t(c2b_t)) ops_2b [`AE_PER_CLASS] ();
    operand_if #(.data_t(c4b_t)) ops_4b [`AE_PER_CLASS] ();
    operand_if #(.data_t(c6b_t)) ops_6b [`AE_PER_CLASS] ();

    // slot 0 sits in the lowest bits of the action vector
    for (genvar s = 0; s < `AE_NUM_SLOTS; s++) begin : g_slot
        assign slots[s] = action_in[s*`AE_SLOT_W +: `AE_SLOT_W];
    end

    for (genvar i = 0; i < `AE_PER_CLASS; i++) begin : g_slice
        assign slots_2b[i] = slots[i];
        assign slots_4b[i] = slots[`AE_PER_CLASS + i];
        assign slots_6b[i] = slots[2*`AE_PER_CLASS + i];
        assign cont_2b[i]  = phv_in[i*`AE_W2B +: `AE_W2B];
        assign cont_4b[i]  = phv_in[OFF_4B + i*`AE_W4B +: `AE_W4B];
        assign cont_6b[i]  = phv_in[OFF_6B + i*`AE_W6B +: `AE_W6B];
    end

    engine_ctrl u_ctrl (
        .clk             (clk),
        .arst_n          (arst_n),
        .phv_valid_in    (phv_valid_in),
        .action_valid_in (action_valid_in),
        .action_in       (slots),
        .ops_2b          (ops_2b),
        .ops_4b          (ops_4b),
        .ops_6b          (ops_6b),
        .phv_valid_out   (phv_valid_out)
    );

    operand_crossbar #(.data_t(c2b_t)) u_xbar_2b (
        .clk        (clk),
        .arst_n     (arst_n),
        .containers (cont_2b),
        .slots      (slots_2b),
        .ops        (ops_2b)
    );

    operand_crossbar #(.data_t(c4b_t)) u_xbar_4b (
        .clk        (clk),
        .arst_n     (arst_n),
        .containers (cont_4b),
        .slots      (slots_4b),
        .ops        (ops_4b)
    );

    operand_crossbar #(.data_t(c6b_t)) u_xbar_6b (
        .clk        (clk),
        .arst_n     (arst_n),
        .containers (cont_6b),
        .slots      (slots_6b),
        .ops        (ops_6b)
    );

    // ALU results go straight back into their header positions
    for (genvar i = 0; i < `AE_PER_CLASS; i++) begin : g_alu
        container_alu #(.data_t(c2b_t)) u_alu_2b (
            .clk    (clk),
            .arst_n (arst_n),
            .ops    (ops_2b[i]),
            .result (phv_out[i*`AE_W2B +: `AE_W2B])
        );

        container_alu #(.data_t(c4b_t)) u_alu_4b (
            .clk    (clk),
            .arst_n (arst_n),
            .ops    (ops_4b[i]),
            .result (phv_out[OFF_4B + i*`AE_W4B +: `AE_W4B])
        );

        container_alu #(.data_t(c6b_t)) u_alu_6b (
            .clk    (clk),
            .arst_n (arst_n),
            .ops    (ops_6b[i]),
            .result (phv_out[OFF_6B + i*`AE_W6B +: `AE_W6B])
        );
    end

endmodule

/* hw/action_engine_pkg.sv */
// action engine package
// opcode, selector, action slot and container types for the
// match-action stage
`include "action_engine_settings.svh"

package action_engine_pkg;

    // per-slot operation
    typedef enum logic [`AE_OPC_W-1:0] {
        OP_NOP = 2'd0,
        OP_ADD = 2'd1,
        OP_SUB = 2'd2,
        OP_SET = 2'd3
    } opcode_e;

    // index of a container inside its own class
    typedef logic [`AE_SEL_W-1:0] container_sel_t;

    // one slot of the action vector, opcode in the top bits
    typedef struct packed {
        opcode_e                opcode;
        logic                   b_is_imm;
        container_sel_t         sel_a;
        container_sel_t         sel_b;
        logic [`AE_IMM_W-1:0]   imm;
    } action_slot_t;

    // container payloads, one to three halfwords
    typedef logic [`AE_W2B-1:0] c2b_t;
    typedef logic [`AE_W4B-1:0] c4b_t;
    typedef logic [`AE_W6B-1:0] c6b_t;

endpackage

/* hw/action_engine_settings.svh */
// action engine settings
// container widths, counts and vector widths shared by the
// match-action stage and its testbench
`ifndef ACTION_ENGINE_SETTINGS_SVH
`define ACTION_ENGINE_SETTINGS_SVH

// container widths per class
`define AE_W2B 16
`define AE_W4B 32
`define AE_W6B 48

// containers per width class and in total
`define AE_PER_CLASS 4
`define AE_NUM_SLOTS 12

// action slot fields
`define AE_IMM_W 16
`define AE_SEL_W 2
`define AE_OPC_W 2
`define AE_SLOT_W 23

// 4x16 + 4x32 + 4x48
`define AE_PHV_W 384

// twelve slots of AE_SLOT_W bits
`define AE_ACT_W 276

`endif

/* hw/container_alu.sv */
// container ALU
// nop, add, sub or set on one container, registered on valid;
// add and sub wrap at the container width
`timescale 1ns/10ps

module container_alu
    import action_engine_pkg::*;
#(
    parameter type data_t = c2b_t
)(
    input  logic    clk,
    input  logic    arst_n,
    operand_if.alu  ops,
    output data_t   result
);

    data_t  result_d;

    always_comb begin
        unique case (ops.opcode)
            OP_ADD:  result_d = ops.operand_a + ops.operand_b;
            OP_SUB:  result_d = ops.operand_a - ops.operand_b;
            OP_SET:  result_d = ops.operand_b;
            default: result_d = ops.own;
        endcase
    end

    // holds the last result between headers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (ops.valid) begin
            result <= result_d;
        end
    end

    a_opcode_known: assert property (@(posedge clk) disable iff (!arst_n)
        ops.valid |-> !$isunknown(ops.opcode));

endmodule

/* hw/engine_ctrl.sv */
// engine control
// registers the slot opcodes and the input strobe, then drives
// each ALU's opcode and valid; the strobe is delayed once more
// to form the header valid output
`timescale 1ns/10ps
`include "action_engine_settings.svh"

module engine_ctrl
    import action_engine_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            phv_valid_in,
    input  logic            action_valid_in,
    input  action_slot_t    action_in [`AE_NUM_SLOTS],
    operand_if.ctrl         ops_2b [`AE_PER_CLASS],
    operand_if.ctrl         ops_4b [`AE_PER_CLASS],
    operand_if.ctrl         ops_6b [`AE_PER_CLASS],
    output logic            phv_valid_out
);

    opcode_e    opcode_q [`AE_NUM_SLOTS];
    logic       valid_q;
    logic       out_valid_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `AE_NUM_SLOTS; i++) begin
                opcode_q[i] <= OP_NOP;
            end
            valid_q     <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            if (action_valid_in) begin
                for (int i = 0; i < `AE_NUM_SLOTS; i++) begin
                    opcode_q[i] <= action_in[i].opcode;
                end
            end
            valid_q     <= phv_valid_in;
            out_valid_q <= valid_q;
        end
    end

    // slot order is 2B, then 4B, then 6B
    for (genvar i = 0; i < `AE_PER_CLASS; i++) begin : g_slot
        assign ops_2b[i].opcode = opcode_q[i];
        assign ops_2b[i].valid  = valid_q;
        assign ops_4b[i].opcode = opcode_q[`AE_PER_CLASS + i];
        assign ops_4b[i].valid  = valid_q;
        assign ops_6b[i].opcode = opcode_q[2*`AE_PER_CLASS + i];
        assign ops_6b[i].valid  = valid_q;
    end

    assign phv_valid_out = out_valid_q;

    // header and action arrive as one strobe
    a_strobes_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        phv_valid_in == action_valid_in);

    // fixed two cycle latency through crossbar and ALU
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        phv_valid_in |-> ##2 phv_valid_out);

endmodule

/* hw/operand_crossbar.sv */
// operand crossbar
// picks operand a, operand b or the immediate, and the own container,
// for every slot of one width class and registers them
`timescale 1ns/10ps
`include "action_engine_settings.svh"

module operand_crossbar
    import action_engine_pkg::*;
#(
    parameter type data_t = c2b_t
)(
    input  logic            clk,
    input  logic            arst_n,
    input  data_t           containers [`AE_PER_CLASS],
    input  action_slot_t    slots [`AE_PER_CLASS],
    operand_if.xbar         ops [`AE_PER_CLASS]
);

    data_t  sel_a_d [`AE_PER_CLASS];
    data_t  sel_b_d [`AE_PER_CLASS];

    for (genvar i = 0; i < `AE_PER_CLASS; i++) begin : g_sel
        // operand a always comes from the class
        assign sel_a_d[i] = containers[slots[i].sel_a];

        // immediate is zero-extended to the container width
        assign sel_b_d[i] = slots[i].b_is_imm ? data_t'(slots[i].imm)
                                              : containers[slots[i].sel_b];

        // loads every cycle, valid travels separately
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                ops[i].own       <= '0;
                ops[i].operand_a <= '0;
                ops[i].operand_b <= '0;
            end else begin
                ops[i].own       <= containers[i];
                ops[i].operand_a <= sel_a_d[i];
                ops[i].operand_b <= sel_b_d[i];
            end
        end
    end

endmodule

/* hw/operand_if.sv */
// operand interface
// carries one slot's operands from the crossbar and its opcode and
// valid from the control block to a container ALU
`timescale 1ns/10ps

interface operand_if
    import action_engine_pkg::*;
#(
    parameter type data_t = c2b_t
);

    data_t      own;
    data_t      operand_a;
    data_t      operand_b;
    opcode_e    opcode;
    logic       valid;

    // operand side
    modport xbar (output own, output operand_a, output operand_b);

    // opcode and strobe side
    modport ctrl (output opcode, output valid);

    modport alu (
        input own,
        input operand_a,
        input operand_b,
        input opcode,
        input valid
    );

endinterface

/* verification/tb_action_engine.sv */
// action engine testbench
// directed phases for each opcode, wrap and latency, then seeded
// random headers with random gaps, checked by tb_checker
`timescale 1ns/10ps
`include "action_engine_settings.svh"

module tb_action_engine
    import action_engine_pkg::*;
();

    logic                   clk;
    logic                   arst_n;
    logic [`AE_PHV_W-1:0]   phv_in;
    logic                   phv_valid_in;
    logic [`AE_ACT_W-1:0]   action_in;
    logic                   action_valid_in;
    logic [`AE_PHV_W-1:0]   phv_out;
    logic                   phv_valid_out;
    int                     in_count;
    int                     out_count;
    int                     err_count;
    int                     tests_run;
    int                     tests_failed;
    int                     err_mark;
    int                     stall_fails;

    tb_clock_gen u_clk (.clk(clk), .arst_n(arst_n));

    action_engine uut (
        .clk             (clk),
        .arst_n          (arst_n),
        .phv_in          (phv_in),
        .phv_valid_in    (phv_valid_in),
        .action_in       (action_in),
        .action_valid_in (action_valid_in),
        .phv_out         (phv_out),
        .phv_valid_out   (phv_valid_out)
    );

    tb_checker u_check (
        .clk           (clk),
        .arst_n        (arst_n),
        .phv_in        (phv_in),
        .phv_valid_in  (phv_valid_in),
        .action_in     (action_in),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .in_count      (in_count),
        .out_count     (out_count),
        .err_count     (err_count)
    );

    function automatic logic [`AE_PHV_W-1:0] random_phv();
        logic [`AE_PHV_W-1:0] v;
        for (int k = 0; k < `AE_PHV_W / 32; k++) begin
            v[k*32 +: 32] = $urandom;
        end
        return v;
    endfunction

    function automatic logic [`AE_ACT_W-1:0] random_action();
        logic [`AE_ACT_W-1:0] v;
        for (int s = 0; s < `AE_NUM_SLOTS; s++) begin
            v[s*`AE_SLOT_W +: `AE_SLOT_W] = $urandom;
        end
        return v;
    endfunction

    // same opcode in every slot, a picks itself, b the next container
    function automatic logic [`AE_ACT_W-1:0] uniform_action(input opcode_e op,
                                                            input logic b_imm,
                                                            input logic [15:0] imm);
        logic [`AE_ACT_W-1:0]   v;
        action_slot_t           sl;
        for (int s = 0; s < `AE_NUM_SLOTS; s++) begin
            sl.opcode   = op;
            sl.b_is_imm = b_imm;
            sl.sel_a    = container_sel_t'(s % 4);
            sl.sel_b    = container_sel_t'((s + 1) % 4);
            sl.imm      = imm + 16'(s);
            v[s*`AE_SLOT_W +: `AE_SLOT_W] = sl;
        end
        return v;
    endfunction

    task automatic send(input logic [`AE_PHV_W-1:0] phv, input logic [`AE_ACT_W-1:0] act);
        @(posedge clk);
        phv_in          <= phv;
        action_in       <= act;
        phv_valid_in    <= 1'b1;
        action_valid_in <= 1'b1;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            phv_valid_in    <= 1'b0;
            action_valid_in <= 1'b0;
        end
    endtask

    // wait until every input has its output, then report the test
    // the last strobe shows up in in_count one edge after it is taken
    task automatic close_test(input string name);
        int waited;
        idle(2);
        waited = 0;
        while (out_count != in_count && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (out_count != in_count) begin
            $display("test %s timed out with %0d outputs for %0d inputs",
                     name, out_count, in_count);
            stall_fails++;
        end
        idle(2);
        tests_run++;
        if (err_count != err_mark || out_count != in_count) begin
            tests_failed++;
            $display("test %-10s FAILED with %0d errors", name, err_count - err_mark);
        end else begin
            $display("test %-10s ok", name);
        end
        err_mark = err_count;
    endtask

    initial begin
        logic [`AE_ACT_W-1:0]   act;
        logic [`AE_ACT_W-1:0]   nop_act;
        int                     waited;
        phv_in          = '0;
        phv_valid_in    = 1'b0;
        action_in       = '0;
        action_valid_in = 1'b0;
        tests_run       = 0;
        tests_failed    = 0;
        err_mark        = 0;
        stall_fails     = 0;
        void'($urandom(32'h319b_c443));

        waited = 0;
        while (arst_n !== 1'b1 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (arst_n !== 1'b1) begin
            $display("reset was never released");
            stall_fails++;
        end

        // nothing sent, so no output may appear
        idle(10);
        close_test("reset_idle");

        send(random_phv(), uniform_action(OP_SET, 1'b1, 16'hff00));
        send(random_phv(), uniform_action(OP_SET, 1'b1, 16'hfff0));
        close_test("set_imm");

        send(random_phv(), uniform_action(OP_SET, 1'b0, 16'h0000));
        send(random_phv(), uniform_action(OP_SET, 1'b0, 16'h1234));
        close_test("set_copy");

        // all ones plus small, zero minus small, near max plus near max
        send('1, uniform_action(OP_ADD, 1'b1, 16'h0001));
        send('0, uniform_action(OP_SUB, 1'b1, 16'h0001));
        send(~(random_phv() & {12{32'h0000_00ff}}), uniform_action(OP_ADD, 1'b0, 16'h0));
        send(random_phv() & {12{32'h0000_00ff}}, uniform_action(OP_SUB, 1'b0, 16'h0));
        close_test("wrap");

        // even slots keep their container while odd slots are overwritten
        nop_act = uniform_action(OP_NOP, 1'b0, 16'h0);
        act     = uniform_action(OP_SET, 1'b1, 16'h5a5a);
        for (int s = 0; s < `AE_NUM_SLOTS; s += 2) begin
            act[s*`AE_SLOT_W +: `AE_SLOT_W] = nop_act[s*`AE_SLOT_W +: `AE_SLOT_W];
        end
        send(random_phv(), nop_act);
        send(random_phv(), act);
        close_test("nop");

        repeat (8) send(random_phv(), random_action());
        close_test("latency");

        repeat (300) begin
            send(random_phv(), random_action());
            idle($urandom_range(0, 3));
        end
        close_test("random");

        $display("%0d tests run, %0d failed, %0d headers in, %0d out, %0d errors",
                 tests_run, tests_failed, in_count, out_count, err_count);
        if (tests_failed == 0 && err_count == 0 && stall_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verification/tb_checker.sv */
// action engine checker
// models each accepted header, queues the expected result and
// compares it with the DUT output two cycles later
`timescale 1ns/10ps
`include "action_engine_settings.svh"

module tb_checker
    import action_engine_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`AE_PHV_W-1:0]    phv_in,
    input  logic                    phv_valid_in,
    input  logic [`AE_ACT_W-1:0]    action_in,
    input  logic [`AE_PHV_W-1:0]    phv_out,
    input  logic                    phv_valid_out,
    output int                      in_count,
    output int                      out_count,
    output int                      err_count
);

    logic [`AE_PHV_W-1:0]   exp_q [$];
    longint                 stamp_q [$];
    longint                 cycle;
    int                     n_in;
    int                     n_out;
    int                     n_err;

    // 16, 32 or 48 bits
    function automatic int cont_width(input int cls);
        return `AE_W2B * (cls + 1);
    endfunction

    function automatic int cont_base(input int cls, input int idx);
        int class_base;
        class_base = (cls == 0) ? 0 : (cls == 1) ? `AE_PER_CLASS * `AE_W2B :
                     `AE_PER_CLASS * (`AE_W2B + `AE_W4B);
        return class_base + idx * cont_width(cls);
    endfunction

    function automatic logic [47:0] read_cont(input logic [`AE_PHV_W-1:0] phv,
                                              input int cls, input int idx);
        logic [47:0] v;
        v = '0;
        for (int k = 0; k < cont_width(cls); k++) begin
            v[k] = phv[cont_base(cls, idx) + k];
        end
        return v;
    endfunction

    // slot rules: nop keeps, add and sub wrap, set takes operand b
    function automatic logic [`AE_PHV_W-1:0] expected_phv(input logic [`AE_PHV_W-1:0] phv,
                                                          input logic [`AE_ACT_W-1:0] act);
        logic [`AE_PHV_W-1:0]   res;
        action_slot_t           sl;
        logic [63:0]            mask;
        logic [47:0]            a;
        logic [47:0]            b;
        logic [47:0]            r;
        int                     cls;
        int                     idx;
        res = '0;
        for (int s = 0; s < `AE_NUM_SLOTS; s++) begin
            cls  = s / `AE_PER_CLASS;
            idx  = s % `AE_PER_CLASS;
            sl   = act[s*`AE_SLOT_W +: `AE_SLOT_W];
            mask = (64'd1 << cont_width(cls)) - 64'd1;
            a    = read_cont(phv, cls, sl.sel_a);
            b    = sl.b_is_imm ? {32'd0, sl.imm} : read_cont(phv, cls, sl.sel_b);
            case (sl.opcode)
                OP_ADD:  r = (a + b) & mask[47:0];
                OP_SUB:  r = (a - b) & mask[47:0];
                OP_SET:  r = b;
                default: r = read_cont(phv, cls, idx);
            endcase
            for (int k = 0; k < cont_width(cls); k++) begin
                res[cont_base(cls, idx) + k] = r[k];
            end
        end
        return res;
    endfunction

    always @(posedge clk or negedge arst_n) begin
        logic [`AE_PHV_W-1:0]   exp_phv;
        longint                 stamp;
        if (!arst_n) begin
            exp_q.delete();
            stamp_q.delete();
            cycle = 0;
            n_in  = 0;
            n_out = 0;
            n_err = 0;
        end else begin
            cycle++;
            if (phv_valid_out) begin
                n_out++;
                if (exp_q.size() == 0) begin
                    $display("output pulse at %0t with no header in flight", $time);
                    n_err++;
                end else begin
                    exp_phv = exp_q.pop_front();
                    stamp   = stamp_q.pop_front();
                    if (cycle - stamp != 2) begin
                        $display("output at %0t came %0d cycles after its input, not 2",
                                 $time, cycle - stamp);
                        n_err++;
                    end
                    for (int s = 0; s < `AE_NUM_SLOTS; s++) begin
                        if (read_cont(phv_out, s / 4, s % 4) !=
                            read_cont(exp_phv, s / 4, s % 4)) begin
                            $display("ERROR %0t phv_out.c%0db[%0d] expected %h got %h",
                                     $time, 2 * (s / 4 + 1), s % 4,
                                     read_cont(exp_phv, s / 4, s % 4),
                                     read_cont(phv_out, s / 4, s % 4));
                            n_err++;
                        end
                    end
                end
            end
            if (phv_valid_in) begin
                exp_q.push_back(expected_phv(phv_in, action_in));
                stamp_q.push_back(cycle);
                n_in++;
            end
            // an output that should have come already
            if (stamp_q.size() > 0 && cycle - stamp_q[0] > 2) begin
                $display("no output pulse for the header taken at %0t",
                         $time - (cycle - stamp_q[0]) * 20);
                void'(exp_q.pop_front());
                void'(stamp_q.pop_front());
                n_err++;
            end
        end
        in_count  <= n_in;
        out_count <= n_out;
        err_count <= n_err;
    end

endmodule

/* verification/tb_clock_gen.sv */
// testbench clock and reset
// 20 ns clock, reset held low for the first three cycles
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
    end

    always #10 clk = ~clk;

    initial begin
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule
